// ==== src/soc_pkg.sv ====
// Shared widths, address map, interrupt constants and types for the SoC; referenced by scoped name
`default_nettype none

package soc_pkg;

  // Bus geometry, one 16-bit word per transfer
  localparam int DAT_W = 16;
  localparam int SEL_W = DAT_W / 8;  // One select bit per byte
  localparam int ADR_W = 19;         // Word address adr[19:1]

  typedef logic [DAT_W-1:0] dat_t;
  typedef logic [SEL_W-1:0] sel_t;
  typedef logic [ADR_W:1]   adr_t;   // Bit 1 is the lowest word-address bit

  // GPIO lives at I/O 0xf100-0xf103
  // Word address 0xf100 >> 1, bit 1 left out of the compare
  localparam adr_t IO_GPIO_BASE = 19'h0_7880;
  localparam adr_t IO_GPIO_MASK = 19'h7_fffe;

  // On-chip RAM, 64 words
  localparam int RAM_AW = 6;

  // GPIO widths
  localparam int LED_W = 12;
  localparam int SW_W  = 10;

  // Interrupts
  localparam int IRQ_N = 8;
  typedef logic [$clog2(IRQ_N)-1:0] iid_t;

  localparam int   IRQ_TIMER     = 0;         // Timer owns line 0
  localparam dat_t INTA_VEC_BASE = 16'h0008;  // Vector = base + id

  // Timer tick spacing in clk cycles
  localparam int TIMER_PERIOD = 256;

  // Value returned for unmapped I/O
  localparam dat_t DEF_RDATA = 16'hffff;

  // Target of the current bus cycle
  typedef enum logic [1:0] {
    SEL_NONE,
    SEL_RAM,
    SEL_GPIO,
    SEL_DEF
  } slave_sel_e;

endpackage

`default_nettype wire

// ==== src/wb_slave_if.sv ====
// Decoded bus port between the address switch and one slave; switch takes master, slave takes slave
`default_nettype none

interface wb_slave_if;

  soc_pkg::adr_t adr;
  soc_pkg::dat_t dat_w;   // Master to slave
  soc_pkg::sel_t sel;
  logic          we;
  logic          cyc;
  logic          stb;
  soc_pkg::dat_t dat_r;   // Slave to master, valid with ack
  logic          ack;

  modport master (
    output adr, dat_w, sel, we, cyc, stb,
    input  dat_r, ack
  );

  modport slave (
    input  adr, dat_w, sel, we, cyc, stb,
    output dat_r, ack
  );

endinterface

`default_nettype wire

// ==== src/wb_switch.sv ====
// Bus address switch: decodes memory/I/O cycles, steers them to RAM or GPIO, answers the rest
`default_nettype none

module wb_switch (
  input  soc_pkg::adr_t m_adr_i,
  input  logic          m_tga_i,   // High for I/O cycles
  input  soc_pkg::dat_t m_dat_i,
  input  soc_pkg::sel_t m_sel_i,
  input  logic          m_we_i,
  input  logic          m_cyc_i,
  input  logic          m_stb_i,
  output soc_pkg::dat_t m_dat_o,
  output logic          m_ack_o,

  wb_slave_if.master    ram,
  wb_slave_if.master    gpio
);

  soc_pkg::slave_sel_e slave_sel;
  logic                gpio_hit;
  logic                def_ack;

  assign gpio_hit = (m_adr_i & soc_pkg::IO_GPIO_MASK) == soc_pkg::IO_GPIO_BASE;

  // Address decode
  always_comb begin
    if (!m_cyc_i) begin
      slave_sel = soc_pkg::SEL_NONE;
    end else if (!m_tga_i) begin
      slave_sel = soc_pkg::SEL_RAM;     // Whole memory space
    end else if (gpio_hit) begin
      slave_sel = soc_pkg::SEL_GPIO;
    end else begin
      slave_sel = soc_pkg::SEL_DEF;
    end
  end

  // Address, data, select and we go to both ports
  assign ram.adr    = m_adr_i;
  assign ram.dat_w  = m_dat_i;
  assign ram.sel    = m_sel_i;
  assign ram.we     = m_we_i;
  assign gpio.adr   = m_adr_i;
  assign gpio.dat_w = m_dat_i;
  assign gpio.sel   = m_sel_i;
  assign gpio.we    = m_we_i;

  // Only the chosen slave sees the cycle
  assign ram.cyc  = m_cyc_i && (slave_sel == soc_pkg::SEL_RAM);
  assign ram.stb  = m_stb_i && (slave_sel == soc_pkg::SEL_RAM);
  assign gpio.cyc = m_cyc_i && (slave_sel == soc_pkg::SEL_GPIO);
  assign gpio.stb = m_stb_i && (slave_sel == soc_pkg::SEL_GPIO);

  // Default responder acks in the strobe cycle
  assign def_ack = m_stb_i && (slave_sel == soc_pkg::SEL_DEF);

  // Return path
  always_comb begin
    case (slave_sel)
      soc_pkg::SEL_RAM: begin
        m_dat_o = ram.dat_r;
        m_ack_o = ram.ack;
      end
      soc_pkg::SEL_GPIO: begin
        m_dat_o = gpio.dat_r;
        m_ack_o = gpio.ack;
      end
      soc_pkg::SEL_DEF: begin
        m_dat_o = soc_pkg::DEF_RDATA;
        m_ack_o = def_ack;
      end
      default: begin
        m_dat_o = '0;          // Idle bus
        m_ack_o = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/wb_ram.sv ====
// 64-word on-chip RAM slave with byte writes, standing in for main memory on the bus
`default_nettype none

module wb_ram (
  input  logic      clk,
  input  logic      rst_lck,
  wb_slave_if.slave bus
);

  soc_pkg::dat_t              mem [0:(2**soc_pkg::RAM_AW)-1];
  soc_pkg::dat_t              rd_q;
  logic [soc_pkg::RAM_AW-1:0] idx;
  logic                       ack_q;
  logic                       req;

  assign idx = bus.adr[soc_pkg::RAM_AW:1];  // Upper bits alias
  assign req = bus.cyc && bus.stb && !ack_q; // No second ack on a held strobe

  // One ack per request
  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  // Write enabled bytes, capture the read word for the ack cycle
  always_ff @(posedge clk) begin
    if (req) begin
      if (bus.we) begin
        for (int i = 0; i < soc_pkg::SEL_W; i++) begin
          if (bus.sel[i]) begin
            mem[idx][8*i +: 8] <= bus.dat_w[8*i +: 8];
          end
        end
      end
      rd_q <= mem[idx];
    end
  end

  assign bus.ack   = ack_q;
  assign bus.dat_r = rd_q;

endmodule

`default_nettype wire

// ==== src/gpio_regs.sv ====
// GPIO slave: byte-writable LED register at the even word, switch readback at the odd word
`default_nettype none

module gpio_regs (
  input  logic                      clk,
  input  logic                      rst_lck,
  wb_slave_if.slave                 bus,
  input  logic [soc_pkg::SW_W-1:0]  sw_i,
  output logic [soc_pkg::LED_W-1:0] leds_o
);

  logic [soc_pkg::LED_W-1:0] leds_q;
  soc_pkg::dat_t             led_next;
  soc_pkg::dat_t             rd_q;
  logic                      ack_q;
  logic                      req;
  logic                      sw_sel;

  assign req    = bus.cyc && bus.stb && !ack_q;
  assign sw_sel = bus.adr[1];               // Set for the switch word

  // Merge the enabled bytes into the LED word
  always_comb begin
    led_next = soc_pkg::dat_t'(leds_q);
    for (int i = 0; i < soc_pkg::SEL_W; i++) begin
      if (bus.sel[i]) begin
        led_next[8*i +: 8] = bus.dat_w[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      ack_q  <= 1'b0;
      leds_q <= '0;
    end else begin
      ack_q <= req;
      if (req && bus.we && !sw_sel) begin
        leds_q <= led_next[soc_pkg::LED_W-1:0];  // Top bits dropped
      end
    end
  end

  // Read data, zero-extended
  always_ff @(posedge clk) begin
    if (req) begin
      rd_q <= sw_sel ? soc_pkg::dat_t'(sw_i) : soc_pkg::dat_t'(leds_q);
    end
  end

  assign bus.ack   = ack_q;
  assign bus.dat_r = rd_q;
  assign leds_o    = leds_q;

endmodule

`default_nettype wire

// ==== src/interval_timer.sv ====
// Free-running interval timer; pulses tick_o for one cycle every PERIOD clocks as an interrupt
`default_nettype none

module interval_timer #(
  parameter int PERIOD = 256   // 2 or more
) (
  input  logic clk,
  input  logic rst_lck,
  output logic tick_o
);

  localparam int CW = $clog2(PERIOD);

  logic [CW-1:0] cnt;
  logic          wrap;

  assign wrap = (cnt == CW'(PERIOD - 1));

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      cnt    <= '0;
      tick_o <= 1'b0;
    end else begin
      // Tick lands PERIOD cycles after reset, then every PERIOD
      if (wrap) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
      tick_o <= wrap;
    end
  end

endmodule

`default_nettype wire

// ==== src/simple_pic.sv ====
// Edge-triggered interrupt controller; lowest pending line wins and is cleared on acknowledge
`default_nettype none

module simple_pic (
  input  logic                      clk,
  input  logic                      rst_lck,
  input  logic [soc_pkg::IRQ_N-1:0] irq_i,
  input  logic                      inta_i,
  output logic                      intr_o,
  output soc_pkg::iid_t             iid_o
);

  logic [soc_pkg::IRQ_N-1:0] irq_q;      // Previous line levels
  logic [soc_pkg::IRQ_N-1:0] pending;
  logic [soc_pkg::IRQ_N-1:0] rise;
  logic [soc_pkg::IRQ_N-1:0] clr;
  logic                      inta_q;

  assign rise = irq_i & ~irq_q;

  // Lowest index first
  always_comb begin
    iid_o = '0;
    for (int i = soc_pkg::IRQ_N - 1; i >= 0; i--) begin
      if (pending[i]) begin
        iid_o = soc_pkg::iid_t'(i);
      end
    end
  end

  // Acknowledge drops the line being serviced
  always_comb begin
    clr = '0;
    if (inta_i && !inta_q) begin
      clr[iid_o] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      irq_q   <= '0;
      inta_q  <= 1'b0;
      pending <= '0;
    end else begin
      irq_q   <= irq_i;
      inta_q  <= inta_i;
      pending <= (pending & ~clr) | rise;  // New edge wins over a clear
    end
  end

  assign intr_o = |pending;

endmodule

`default_nettype wire

// ==== src/soc_top.sv ====
// SoC bus and interrupt core top level; an external bus master drives the Wishbone-style port
`default_nettype none

module soc_top (
  input  logic                      clk,
  input  logic                      rst_lck,

  // Bus master port
  input  soc_pkg::adr_t             m_adr_i,
  input  logic                      m_tga_i,
  input  soc_pkg::dat_t             m_dat_i,
  input  soc_pkg::sel_t             m_sel_i,
  input  logic                      m_we_i,
  input  logic                      m_cyc_i,
  input  logic                      m_stb_i,
  output soc_pkg::dat_t             m_dat_o,
  output logic                      m_ack_o,

  // Interrupts
  input  logic                      inta_i,
  input  logic [soc_pkg::IRQ_N-1:1] irq_i,
  output logic                      intr_o,

  // GPIO pins
  input  logic [soc_pkg::SW_W-1:0]  sw_i,
  output logic [soc_pkg::LED_W-1:0] leds_o
);

  wb_slave_if ram_bus ();
  wb_slave_if gpio_bus ();

  soc_pkg::dat_t             sw_dat;
  soc_pkg::iid_t             iid;
  logic [soc_pkg::IRQ_N-1:0] irq_lines;
  logic                      timer_tick;

  wb_switch wbs (
    .m_adr_i (m_adr_i),
    .m_tga_i (m_tga_i),
    .m_dat_i (m_dat_i),
    .m_sel_i (m_sel_i),
    .m_we_i  (m_we_i),
    .m_cyc_i (m_cyc_i),
    .m_stb_i (m_stb_i),
    .m_dat_o (sw_dat),
    .m_ack_o (m_ack_o),
    .ram     (ram_bus.master),
    .gpio    (gpio_bus.master)
  );

  wb_ram ram0 (
    .clk     (clk),
    .rst_lck (rst_lck),
    .bus     (ram_bus.slave)
  );

  gpio_regs gpio0 (
    .clk     (clk),
    .rst_lck (rst_lck),
    .bus     (gpio_bus.slave),
    .sw_i    (sw_i),
    .leds_o  (leds_o)
  );

  interval_timer #(
    .PERIOD (soc_pkg::TIMER_PERIOD)
  ) timer0 (
    .clk     (clk),
    .rst_lck (rst_lck),
    .tick_o  (timer_tick)
  );

  // Timer joins the external lines
  always_comb begin
    irq_lines = {irq_i, 1'b0};
    irq_lines[soc_pkg::IRQ_TIMER] = timer_tick;
  end

  simple_pic pic0 (
    .clk     (clk),
    .rst_lck (rst_lck),
    .irq_i   (irq_lines),
    .inta_i  (inta_i),
    .intr_o  (intr_o),
    .iid_o   (iid)
  );

  // Vector replaces bus data during acknowledge
  assign m_dat_o = inta_i ? soc_pkg::INTA_VEC_BASE + soc_pkg::dat_t'(iid) : sw_dat;

endmodule

`default_nettype wire

// ==== verif/soc_asserts.sv ====
// Concurrent checks on the SoC top-level bus and interrupt ports, attached to soc_top by bind
`default_nettype none

module soc_asserts (
  input logic clk,
  input logic rst_lck,
  input logic m_cyc_i,
  input logic m_stb_i,
  input logic m_ack_i,
  input logic intr_i
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;   // Failed assertions so far

  // Ack belongs to an active strobe
  ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_lck)
    m_ack_i |-> (m_cyc_i && m_stb_i))
    else begin
      $error("ack seen without cyc and stb");
      fail_cnt++;
    end

  // No request pending out of reset
  intr_after_reset: assert property (@(posedge clk) !rst_lck |=> !intr_i)
    else begin
      $error("intr high in the cycle after reset");
      fail_cnt++;
    end

  // Slaves never stall past one cycle
  ack_latency: assert property (@(posedge clk) disable iff (!rst_lck)
    (m_cyc_i && m_stb_i && !m_ack_i) |=> m_ack_i)
    else begin
      $error("ack later than one cycle after stb");
      fail_cnt++;
    end

endmodule

bind soc_top soc_asserts asserts (
  .clk     (clk),
  .rst_lck (rst_lck),
  .m_cyc_i (m_cyc_i),
  .m_stb_i (m_stb_i),
  .m_ack_i (m_ack_o),
  .intr_i  (intr_o)
);

`default_nettype wire

// ==== verif/tb_soc.sv ====
// Testbench for soc_top: acts as the bus master, runs a table of bus cycles, then checks interrupts
`default_nettype none

module tb_soc;

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [19:0] GPIO_BYTE = 20'h0f100;  // Bits 1:0 pick the word
  localparam int          ACK_LIMIT = 4;
  localparam logic [soc_pkg::SW_W-1:0] SW_VALUE = 10'h2b5;

  typedef struct packed {
    logic                      wr;
    logic                      io;
    soc_pkg::adr_t             adr;
    soc_pkg::dat_t             wdat;
    soc_pkg::sel_t             sel;
    soc_pkg::dat_t             exp;    // Expected read data
    logic                      lat;    // Expected ack delay in cycles
    logic [soc_pkg::LED_W-1:0] leds;   // LED state once the entry is done
  } entry_t;

  logic clk, rst_lck;
  soc_pkg::adr_t m_adr_i;
  soc_pkg::dat_t m_dat_i, m_dat_o;
  soc_pkg::sel_t m_sel_i;
  logic m_tga_i, m_we_i, m_cyc_i, m_stb_i, m_ack_o;
  logic inta_i, intr_o;
  logic [soc_pkg::IRQ_N-1:1] irq_i;
  logic [soc_pkg::SW_W-1:0]  sw_i;
  logic [soc_pkg::LED_W-1:0] leds_o;

  entry_t                    table_q[$];
  soc_pkg::dat_t             ram_model [0:63];
  logic [soc_pkg::LED_W-1:0] led_model = '0;
  integer                    seed;
  int errors = 0;
  int tests = 0;
  int cycle = 0;
  int limit_cycles = 0;
  int rst_cycle, tick_cycle, elapsed;

  soc_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Run limit counted in clocks
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (limit_cycles > 0 && cycle >= limit_cycles) begin
      $display("Timeout: the run did not finish within %0d clock cycles", limit_cycles);
      $display("test failed");
      $finish;
    end
  end

  function automatic soc_pkg::dat_t merge_bytes(soc_pkg::dat_t old, soc_pkg::dat_t data,
                                                soc_pkg::sel_t sel);
    soc_pkg::dat_t res;
    res = old;
    if (sel[0]) res[7:0] = data[7:0];
    if (sel[1]) res[15:8] = data[15:8];
    return res;
  endfunction

  function automatic soc_pkg::dat_t rand_word();
    logic [31:0] r;
    r = $random(seed);
    return r[15:0];
  endfunction

  // Appends one bus cycle and updates the reference model
  task automatic add_entry(input logic wr, input logic io, input logic [19:0] baddr,
                           input soc_pkg::dat_t data, input soc_pkg::sel_t sel);
    entry_t        e;
    logic          gpio_hit;
    soc_pkg::dat_t merged;
    gpio_hit = io && (baddr[19:2] == GPIO_BYTE[19:2]);
    e.wr   = wr;
    e.io   = io;
    e.adr  = baddr[19:1];
    e.wdat = data;
    e.sel  = sel;
    e.lat  = !io || gpio_hit;   // Unmapped I/O acks at once
    if (!io) begin
      if (wr) ram_model[baddr[6:1]] = merge_bytes(ram_model[baddr[6:1]], data, sel);
      e.exp = ram_model[baddr[6:1]];
    end else if (gpio_hit && !baddr[1]) begin
      if (wr) begin
        merged    = merge_bytes(soc_pkg::dat_t'(led_model), data, sel);
        led_model = merged[soc_pkg::LED_W-1:0];
      end
      e.exp = soc_pkg::dat_t'(led_model);
    end else if (gpio_hit) begin
      e.exp = soc_pkg::dat_t'(SW_VALUE);  // Switch word is read only
    end else begin
      e.exp = 16'hffff;
    end
    e.leds = led_model;
    table_q.push_back(e);
  endtask

  task automatic run_entry(input int n, input entry_t e);
    soc_pkg::dat_t rdata;
    int            waits;
    int            err_before;
    logic          got_ack;
    waits      = 0;
    got_ack    = 1'b0;
    rdata      = '0;
    err_before = errors;
    @(posedge clk);
    m_adr_i <= e.adr;
    m_tga_i <= e.io;
    m_dat_i <= e.wdat;
    m_sel_i <= e.sel;
    m_we_i  <= e.wr;
    m_cyc_i <= 1'b1;
    m_stb_i <= 1'b1;
    while (!got_ack && waits <= ACK_LIMIT) begin
      @(negedge clk);
      if (m_ack_o) begin
        got_ack = 1'b1;
        rdata   = m_dat_o;
      end else begin
        waits++;
      end
    end
    @(posedge clk);
    m_cyc_i <= 1'b0;
    m_stb_i <= 1'b0;
    m_we_i  <= 1'b0;
    @(negedge clk);
    tests++;
    if (!got_ack) begin
      $display("Entry %0d got no ack within %0d cycles", n, ACK_LIMIT + 1);
      errors++;
    end else if (waits != int'(e.lat)) begin
      $display("[FAIL] t=%0t entry %0d ack after %0d cycles, expected %0d", $time, n, waits,
               e.lat);
      errors++;
    end
    if (got_ack && !e.wr && rdata !== e.exp) begin
      $display("[FAIL] t=%0t entry %0d read %04h, expected %04h", $time, n, rdata, e.exp);
      errors++;
    end
    if (leds_o !== e.leds) begin
      $display("[FAIL] t=%0t entry %0d leds %03h, expected %03h", $time, n, leds_o, e.leds);
      errors++;
    end
    $display("Entry %0d %s %s %05h: %s", n, e.wr ? "wr" : "rd", e.io ? "io " : "mem",
             {e.adr, 1'b0}, (errors == err_before) ? "ok" : "bad");
  endtask

  task automatic wait_intr(input int max_cycles, input string what);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!intr_o && n < max_cycles);
    if (!intr_o) begin
      $display("The %s interrupt never raised intr_o within %0d cycles", what, max_cycles);
      errors++;
    end
  endtask

  // One acknowledge cycle that ends at the falling edge after inta drops
  task automatic inta_cycle(input soc_pkg::dat_t exp_vec);
    @(posedge clk);
    inta_i <= 1'b1;
    @(negedge clk);
    tests++;
    if (m_dat_o !== exp_vec) begin
      $display("[FAIL] t=%0t vector %04h, expected %04h", $time, m_dat_o, exp_vec);
      errors++;
    end else begin
      $display("Acknowledge vector %04h ok", m_dat_o);
    end
    @(posedge clk);
    inta_i <= 1'b0;
    @(negedge clk);
  endtask

  initial begin
    seed = 32'hb0ed;
    rst_lck <= 1'b0;
    m_adr_i <= '0;
    m_tga_i <= 1'b0;
    m_dat_i <= '0;
    m_sel_i <= '0;
    m_we_i  <= 1'b0;
    m_cyc_i <= 1'b0;
    m_stb_i <= 1'b0;
    inta_i  <= 1'b0;
    irq_i   <= '0;
    sw_i    <= SW_VALUE;
    foreach (ram_model[i]) ram_model[i] = '0;

    // Full RAM words, byte lanes and aliases
    add_entry(1'b1, 1'b0, 20'h00006, rand_word(), 2'b11);
    add_entry(1'b1, 1'b0, 20'h0000e, rand_word(), 2'b11);
    add_entry(1'b1, 1'b0, 20'h00028, rand_word(), 2'b11);
    add_entry(1'b1, 1'b0, 20'h0005a, rand_word(), 2'b11);
    add_entry(1'b0, 1'b0, 20'h00006, '0, 2'b11);
    add_entry(1'b0, 1'b0, 20'h0000e, '0, 2'b11);
    add_entry(1'b0, 1'b0, 20'h00028, '0, 2'b11);
    add_entry(1'b0, 1'b0, 20'h0005a, '0, 2'b11);
    add_entry(1'b1, 1'b0, 20'h0000e, rand_word(), 2'b01);
    add_entry(1'b1, 1'b0, 20'h00028, rand_word(), 2'b10);
    add_entry(1'b0, 1'b0, 20'h0000e, '0, 2'b11);
    add_entry(1'b0, 1'b0, 20'h00028, '0, 2'b11);
    add_entry(1'b0, 1'b0, 20'h0008e, '0, 2'b11);   // Index 7 plus 64
    add_entry(1'b0, 1'b0, 20'h000a8, '0, 2'b11);
    add_entry(1'b0, 1'b0, 20'ha005a, '0, 2'b11);
    // GPIO
    add_entry(1'b1, 1'b1, 20'h0f100, rand_word(), 2'b11);
    add_entry(1'b0, 1'b1, 20'h0f100, '0, 2'b11);
    add_entry(1'b0, 1'b1, 20'h0f102, '0, 2'b11);
    add_entry(1'b1, 1'b1, 20'h0f102, rand_word(), 2'b11);
    add_entry(1'b0, 1'b1, 20'h0f100, '0, 2'b11);
    add_entry(1'b0, 1'b1, 20'h0f102, '0, 2'b11);
    add_entry(1'b1, 1'b1, 20'h0f100, rand_word(), 2'b10);
    add_entry(1'b0, 1'b1, 20'h0f100, '0, 2'b11);
    // Unmapped I/O followed by a memory cycle at the GPIO address
    add_entry(1'b0, 1'b1, 20'h00360, '0, 2'b11);
    add_entry(1'b1, 1'b1, 20'h00360, rand_word(), 2'b11);
    add_entry(1'b0, 1'b1, 20'h0f104, '0, 2'b11);
    add_entry(1'b1, 1'b0, 20'h0f100, rand_word(), 2'b11);
    add_entry(1'b0, 1'b0, 20'h00000, '0, 2'b11);
    limit_cycles = table_q.size() * 8 + 4 * soc_pkg::TIMER_PERIOD;

    repeat (4) @(posedge clk);
    rst_lck <= 1'b1;
    rst_cycle = cycle;
    @(negedge clk);
    tests++;
    if (leds_o !== '0 || intr_o !== 1'b0) begin
      $display("[FAIL] t=%0t after reset leds %03h intr %b", $time, leds_o, intr_o);
      errors++;
    end
    $display("Reset state checked");

    foreach (table_q[i]) run_entry(i, table_q[i]);

    // Timer on line 0
    wait_intr(2 * soc_pkg::TIMER_PERIOD, "timer");
    tick_cycle = cycle;
    elapsed    = tick_cycle - rst_cycle;
    tests++;
    if (elapsed < soc_pkg::TIMER_PERIOD || elapsed > soc_pkg::TIMER_PERIOD + 4) begin
      $display("[FAIL] t=%0t timer interrupt after %0d cycles", $time, elapsed);
      errors++;
    end else begin
      $display("Timer interrupt after %0d cycles ok", elapsed);
    end
    inta_cycle(16'h0008);
    if (intr_o !== 1'b0) begin
      $display("[FAIL] t=%0t intr_o still high after timer acknowledge", $time);
      errors++;
    end

    // Lines 3 and 5 together are served lowest first
    @(posedge clk);
    irq_i[3] <= 1'b1;
    irq_i[5] <= 1'b1;
    wait_intr(4, "external");
    inta_cycle(16'h000b);
    if (intr_o !== 1'b1) begin
      $display("[FAIL] t=%0t intr_o low with line 5 pending", $time);
      errors++;
    end
    inta_cycle(16'h000d);
    if (intr_o !== 1'b0 || cycle - tick_cycle >= soc_pkg::TIMER_PERIOD) begin
      $display("[FAIL] t=%0t intr_o %b at %0d cycles after the tick", $time, intr_o,
               cycle - tick_cycle);
      errors++;
    end
    @(posedge clk);
    irq_i <= '0;

    errors += uut.asserts.fail_cnt;
    $display("Tests %0d, failed checks %0d, assertion failures %0d", tests, errors,
             uut.asserts.fail_cnt);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
src/soc_pkg.sv
src/wb_slave_if.sv
src/wb_switch.sv
src/wb_ram.sv
src/gpio_regs.sv
src/interval_timer.sv
src/simple_pic.sv
src/soc_top.sv
verif/soc_asserts.sv
verif/tb_soc.sv

// ==== Makefile ====
# Verilator build and run of the SoC testbench

VERILATOR ?= verilator
TOP       ?= tb_soc
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   list these targets"
	@echo "Overridable: VERILATOR TOP FLIST OBJ_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation result: PASS"; \
	else \
	  echo "Simulation result: FAIL, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
